/* rtl/vec_pkg.sv */
/*
 * Vector unit package
 * Sizes of the lane array and register file, derived widths
 * and the instruction opcode encoding shared by all stages.
 */

`default_nettype none

package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Must stay a power of two
  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEM_W         = 32;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEMS_PER_LANE = 4;
  localparam int unsigned VLMAX          = NR_LANES * ELEMS_PER_LANE;

  ////////////////////////////////////////
  // Derived widths
  ////////////////////////////////////////

  localparam int unsigned VREG_W     = (NR_VREGS > 1) ? $clog2(NR_VREGS) : 1;
  // Holds 0 up to and including VLMAX
  localparam int unsigned VL_W       = $clog2(VLMAX + 1);
  localparam int unsigned ELEM_IDX_W = (ELEMS_PER_LANE > 1) ? $clog2(ELEMS_PER_LANE) : 1;
  localparam int unsigned LANE_ID_W  = (NR_LANES > 1) ? $clog2(NR_LANES) : 1;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_VSETVL  = 4'd0,
    OP_VADD_VV = 4'd1,
    OP_VSUB_VV = 4'd2,
    OP_VAND_VV = 4'd3,
    OP_VOR_VV  = 4'd4,
    OP_VXOR_VV = 4'd5,
    OP_VADD_VX = 4'd6,
    OP_VMV_V_X = 4'd7,
    OP_VID     = 4'd8,
    // Scalar result ops
    OP_VREDSUM = 4'd9,
    OP_VMV_X_S = 4'd10
  } vec_op_e;

endpackage

`default_nettype wire

/* rtl/vec_lane.sv */
/*
 * Vector lane
 * Holds one slice of every vector register and an integer ALU.
 * After a start it walks its local elements one per cycle,
 * writing active elements of vd and forming a partial scalar.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_lane import vec_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic [LANE_ID_W-1:0] lane_id_i,
  // Broadcast from the sequencer
  input  wire logic                 start_i,
  input  wire vec_op_e              op_i,
  input  wire logic [VREG_W-1:0]    vd_i,
  input  wire logic [VREG_W-1:0]    vs1_i,
  input  wire logic [VREG_W-1:0]    vs2_i,
  input  wire logic [ELEM_W-1:0]    scalar_i,
  input  wire logic [VL_W-1:0]      vl_i,
  // Completion
  output logic                      done_o,
  output logic [ELEM_W-1:0]         result_o
);

  localparam logic [ELEM_IDX_W-1:0] LAST_IDX = ELEM_IDX_W'(ELEMS_PER_LANE - 1);

  // Register file slice
  logic [ELEM_W-1:0]     vrf_q [NR_VREGS][ELEMS_PER_LANE];

  logic                  busy_q;
  logic [ELEM_IDX_W-1:0] idx_q;
  vec_op_e               op_q;
  logic [VREG_W-1:0]     vd_q;
  logic [VREG_W-1:0]     vs1_q;
  logic [VREG_W-1:0]     vs2_q;
  logic [ELEM_W-1:0]     scalar_q;
  logic [VL_W-1:0]       vl_q;
  logic [ELEM_W-1:0]     acc_q;
  logic [ELEM_W-1:0]     acc_d;
  logic [ELEM_W-1:0]     opa;
  logic [ELEM_W-1:0]     opb;
  logic [ELEM_W-1:0]     alu_res;
  logic                  alu_wr;
  logic [VL_W-1:0]       gidx;
  logic                  active;
  logic [ELEM_IDX_W-1:0] tgt_idx;

  // Global element index of the current local slot
  assign gidx    = VL_W'(idx_q) * VL_W'(NR_LANES) + VL_W'(lane_id_i);
  assign active  = gidx < vl_q;
  assign tgt_idx = ELEM_IDX_W'(scalar_q / NR_LANES);

  assign opa = vrf_q[vs1_q][idx_q];
  assign opb = vrf_q[vs2_q][idx_q];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    alu_wr  = 1'b1;
    alu_res = '0;
    acc_d   = acc_q;
    case (op_q)
      OP_VADD_VV: alu_res = opb + opa;
      OP_VSUB_VV: alu_res = opb - opa;
      OP_VAND_VV: alu_res = opb & opa;
      OP_VOR_VV:  alu_res = opb | opa;
      OP_VXOR_VV: alu_res = opb ^ opa;
      OP_VADD_VX: alu_res = opb + scalar_q;
      OP_VMV_V_X: alu_res = scalar_q;
      OP_VID:     alu_res = ELEM_W'(gidx);
      OP_VREDSUM: begin
        alu_wr = 1'b0;
        if (active) begin
          acc_d = acc_q + opb;
        end
      end
      OP_VMV_X_S: begin
        alu_wr = 1'b0;
        // Element read ignores vl
        if (idx_q == tgt_idx) begin
          acc_d = opb;
        end
      end
      default: alu_wr = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (busy_q) begin
      idx_q <= idx_q + 1'b1;
      if (idx_q == LAST_IDX) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operation fields and partial scalar
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q     <= op_i;
      vd_q     <= vd_i;
      vs1_q    <= vs1_i;
      vs2_q    <= vs2_i;
      scalar_q <= scalar_i;
      vl_q     <= vl_i;
      acc_q    <= '0;
    end else if (busy_q) begin
      acc_q <= acc_d;
    end
  end

  // Tail elements stay undisturbed
  always_ff @(posedge clk_i) begin
    if (busy_q && alu_wr && active) begin
      vrf_q[vd_q][idx_q] <= alu_res;
    end
  end

  assign done_o   = busy_q && (idx_q == LAST_IDX);
  assign result_o = acc_d;

endmodule

`default_nettype wire

/* rtl/vec_sequencer.sv */
/*
 * Vector sequencer
 * Starts every lane on the issued operation, tracks outstanding
 * lanes in a pending mask and builds the scalar result of
 * VREDSUM and VMV_X_S from the lane results.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_sequencer import vec_pkg::*; (
  input  wire logic                             clk_i,
  input  wire logic                             rst_i,
  // Dispatcher side
  input  wire logic                             issue_valid_i,
  input  wire vec_op_e                          issue_op_i,
  input  wire logic [VREG_W-1:0]                issue_vd_i,
  input  wire logic [VREG_W-1:0]                issue_vs1_i,
  input  wire logic [VREG_W-1:0]                issue_vs2_i,
  input  wire logic [ELEM_W-1:0]                issue_scalar_i,
  input  wire logic [VL_W-1:0]                  issue_vl_i,
  output logic                                  seq_busy_o,
  // Lane side
  input  wire logic [NR_LANES-1:0]              lane_done_i,
  input  wire logic [NR_LANES-1:0][ELEM_W-1:0]  lane_result_i,
  output logic                                  lane_start_o,
  output vec_op_e                               lane_op_o,
  output logic [VREG_W-1:0]                     lane_vd_o,
  output logic [VREG_W-1:0]                     lane_vs1_o,
  output logic [VREG_W-1:0]                     lane_vs2_o,
  output logic [ELEM_W-1:0]                     lane_scalar_o,
  output logic [VL_W-1:0]                       lane_vl_o,
  // Scalar response
  output logic                                  seq_resp_valid_o,
  output logic [ELEM_W-1:0]                     seq_resp_o
);

  logic                 busy_q;
  logic [NR_LANES-1:0]  pending_q;
  logic                 all_done;
  logic                 resp_valid_q;
  vec_op_e              op_q;
  logic [LANE_ID_W-1:0] sel_q;
  logic [ELEM_W-1:0]    resp_q;
  logic [ELEM_W-1:0]    resp_d;

  // Broadcast straight from the issue register
  assign lane_start_o  = issue_valid_i & ~busy_q;
  assign lane_op_o     = issue_op_i;
  assign lane_vd_o     = issue_vd_i;
  assign lane_vs1_o    = issue_vs1_i;
  assign lane_vs2_o    = issue_vs2_i;
  assign lane_scalar_o = issue_scalar_i;
  assign lane_vl_o     = issue_vl_i;

  assign all_done = busy_q && ((pending_q & ~lane_done_i) == '0);

  // Fold in results of lanes reporting this cycle
  always_comb begin
    resp_d = resp_q;
    for (int l = 0; l < NR_LANES; l++) begin
      if (lane_done_i[l] && pending_q[l]) begin
        if (op_q == OP_VREDSUM) begin
          resp_d = resp_d + lane_result_i[l];
        end else if ((op_q == OP_VMV_X_S) && (sel_q == LANE_ID_W'(l))) begin
          resp_d = lane_result_i[l];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      pending_q    <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      if (lane_start_o) begin
        busy_q    <= 1'b1;
        pending_q <= '1;
      end else if (busy_q) begin
        pending_q <= pending_q & ~lane_done_i;
        if (all_done) begin
          busy_q       <= 1'b0;
          resp_valid_q <= (op_q == OP_VREDSUM) || (op_q == OP_VMV_X_S);
        end
      end
    end
  end

  // Element e sits in lane e mod NR_LANES
  always_ff @(posedge clk_i) begin
    if (lane_start_o) begin
      op_q   <= issue_op_i;
      sel_q  <= LANE_ID_W'(issue_scalar_i % NR_LANES);
      resp_q <= '0;
    end else if (busy_q) begin
      resp_q <= resp_d;
    end
  end

  assign seq_busy_o       = busy_q;
  assign seq_resp_valid_o = resp_valid_q;
  assign seq_resp_o       = resp_q;

endmodule

`default_nettype wire

/* rtl/vec_dispatcher.sv */
/*
 * Vector dispatcher
 * Accepts one instruction at a time over valid/ready, keeps the
 * architectural vector length and answers VSETVL directly. All
 * other opcodes are registered and issued to the sequencer.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_dispatcher import vec_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  // Instruction port
  input  wire logic              insn_valid_i,
  input  wire vec_op_e           op_i,
  input  wire logic [VREG_W-1:0] vd_i,
  input  wire logic [VREG_W-1:0] vs1_i,
  input  wire logic [VREG_W-1:0] vs2_i,
  input  wire logic [ELEM_W-1:0] scalar_i,
  output logic                   insn_ready_o,
  // Sequencer side
  input  wire logic              seq_busy_i,
  output logic                   issue_valid_o,
  output vec_op_e                issue_op_o,
  output logic [VREG_W-1:0]      issue_vd_o,
  output logic [VREG_W-1:0]      issue_vs1_o,
  output logic [VREG_W-1:0]      issue_vs2_o,
  output logic [ELEM_W-1:0]      issue_scalar_o,
  output logic [VL_W-1:0]        issue_vl_o,
  // VSETVL answer
  output logic                   vl_resp_valid_o,
  output logic [ELEM_W-1:0]      vl_resp_o
);

  logic              accept;
  logic [VL_W-1:0]   vl_q;
  logic [VL_W-1:0]   vl_clamped;
  logic              issue_valid_q;
  logic              vl_resp_valid_q;

  assign insn_ready_o = ~issue_valid_q & ~seq_busy_i;
  assign accept       = insn_valid_i & insn_ready_o;

  // Requested length saturates at VLMAX
  assign vl_clamped = (scalar_i > ELEM_W'(VLMAX)) ? VL_W'(VLMAX) : scalar_i[VL_W-1:0];

  ////////////////////////////////////////
  // Control state and vl register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_valid_q   <= 1'b0;
      vl_resp_valid_q <= 1'b0;
      vl_q            <= VL_W'(VLMAX);
    end else begin
      issue_valid_q   <= accept && (op_i != OP_VSETVL);
      vl_resp_valid_q <= accept && (op_i == OP_VSETVL);
      if (accept && (op_i == OP_VSETVL)) begin
        vl_q <= vl_clamped;
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_op_o     <= op_i;
      issue_vd_o     <= vd_i;
      issue_vs1_o    <= vs1_i;
      issue_vs2_o    <= vs2_i;
      issue_scalar_o <= scalar_i;
    end
  end

  assign issue_valid_o   = issue_valid_q;
  assign issue_vl_o      = vl_q;
  assign vl_resp_valid_o = vl_resp_valid_q;
  assign vl_resp_o       = ELEM_W'(vl_q);

endmodule

`default_nettype wire

/* rtl/vec_unit.sv */
/*
 * Vector unit top level
 * Dispatcher, sequencer and a generated row of lanes. The VSETVL
 * answer and the sequencer's scalar answer share one response port.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_unit import vec_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              insn_valid_i,
  input  wire vec_op_e           op_i,
  input  wire logic [VREG_W-1:0] vd_i,
  input  wire logic [VREG_W-1:0] vs1_i,
  input  wire logic [VREG_W-1:0] vs2_i,
  input  wire logic [ELEM_W-1:0] scalar_i,
  output logic                   insn_ready_o,
  output logic                   resp_valid_o,
  output logic [ELEM_W-1:0]      resp_data_o
);

  ////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////

  logic              issue_valid;
  vec_op_e           issue_op;
  logic [VREG_W-1:0] issue_vd;
  logic [VREG_W-1:0] issue_vs1;
  logic [VREG_W-1:0] issue_vs2;
  logic [ELEM_W-1:0] issue_scalar;
  logic [VL_W-1:0]   issue_vl;
  logic              seq_busy;
  logic              vl_resp_valid;
  logic [ELEM_W-1:0] vl_resp;

  vec_dispatcher dispatcher0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .insn_valid_i    (insn_valid_i),
    .op_i            (op_i),
    .vd_i            (vd_i),
    .vs1_i           (vs1_i),
    .vs2_i           (vs2_i),
    .scalar_i        (scalar_i),
    .insn_ready_o    (insn_ready_o),
    .seq_busy_i      (seq_busy),
    .issue_valid_o   (issue_valid),
    .issue_op_o      (issue_op),
    .issue_vd_o      (issue_vd),
    .issue_vs1_o     (issue_vs1),
    .issue_vs2_o     (issue_vs2),
    .issue_scalar_o  (issue_scalar),
    .issue_vl_o      (issue_vl),
    .vl_resp_valid_o (vl_resp_valid),
    .vl_resp_o       (vl_resp)
  );

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  logic                            lane_start;
  vec_op_e                         lane_op;
  logic [VREG_W-1:0]               lane_vd;
  logic [VREG_W-1:0]               lane_vs1;
  logic [VREG_W-1:0]               lane_vs2;
  logic [ELEM_W-1:0]               lane_scalar;
  logic [VL_W-1:0]                 lane_vl;
  logic [NR_LANES-1:0]             lane_done;
  logic [NR_LANES-1:0][ELEM_W-1:0] lane_result;
  logic                            seq_resp_valid;
  logic [ELEM_W-1:0]               seq_resp;

  vec_sequencer sequencer0 (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .issue_valid_i    (issue_valid),
    .issue_op_i       (issue_op),
    .issue_vd_i       (issue_vd),
    .issue_vs1_i      (issue_vs1),
    .issue_vs2_i      (issue_vs2),
    .issue_scalar_i   (issue_scalar),
    .issue_vl_i       (issue_vl),
    .seq_busy_o       (seq_busy),
    .lane_done_i      (lane_done),
    .lane_result_i    (lane_result),
    .lane_start_o     (lane_start),
    .lane_op_o        (lane_op),
    .lane_vd_o        (lane_vd),
    .lane_vs1_o       (lane_vs1),
    .lane_vs2_o       (lane_vs2),
    .lane_scalar_o    (lane_scalar),
    .lane_vl_o        (lane_vl),
    .seq_resp_valid_o (seq_resp_valid),
    .seq_resp_o       (seq_resp)
  );

  // Lanes
  for (genvar g = 0; g < NR_LANES; g++) begin : gen_lanes
    vec_lane lane0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .lane_id_i (LANE_ID_W'(g)),
      .start_i   (lane_start),
      .op_i      (lane_op),
      .vd_i      (lane_vd),
      .vs1_i     (lane_vs1),
      .vs2_i     (lane_vs2),
      .scalar_i  (lane_scalar),
      .vl_i      (lane_vl),
      .done_o    (lane_done[g]),
      .result_o  (lane_result[g])
    );
  end

  // Never both in one cycle
  assign resp_valid_o = vl_resp_valid | seq_resp_valid;
  assign resp_data_o  = vl_resp_valid ? vl_resp : seq_resp;

endmodule

`default_nettype wire

/* sim/vec_unit_assertions.sv */
/*
 * Vector unit interface assertions
 * Response pulse width, ready after reset and responses only
 * for accepted instructions. Bound into the top level.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_unit_assertions (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic insn_valid_i,
  input wire logic insn_ready_i,
  input wire logic resp_valid_i
);

  int   fail_cnt = 0;
  logic pending_q;

  // Set by an accept, cleared by a response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (insn_valid_i && insn_ready_i) begin
      pending_q <= 1'b1;
    end else if (resp_valid_i) begin
      pending_q <= 1'b0;
    end
  end

  resp_single_pulse: assert property (
    @(posedge clk_i) disable iff (rst_i) resp_valid_i |=> !resp_valid_i
  ) else begin
    fail_cnt++;
    $error("resp_valid_o held for two cycles");
  end

  ready_after_reset: assert property (
    @(posedge clk_i) $fell(rst_i) |-> insn_ready_i
  ) else begin
    fail_cnt++;
    $error("insn_ready_o low in the cycle after reset");
  end

  resp_needs_accept: assert property (
    @(posedge clk_i) disable iff (rst_i) resp_valid_i |-> pending_q
  ) else begin
    fail_cnt++;
    $error("Response without an accepted instruction");
  end

endmodule

bind vec_unit vec_unit_assertions assertions0 (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .insn_valid_i (insn_valid_i),
  .insn_ready_i (insn_ready_o),
  .resp_valid_i (resp_valid_o)
);

`default_nettype wire

/* sim/vec_unit_tb.sv */
/*
 * Vector unit testbench
 * Directed tests against a register file and vl reference model.
 * Covers VSETVL clamping, splat and index fill, element-wise ALU ops,
 * tail elements, sum reductions and holding an instruction while busy.
 */

`timescale 1ns/1ps
`default_nettype none

module vec_unit_tb import vec_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 100;
  // Upper bound on instructions issued by all tests together
  localparam int unsigned NR_INSNS    = 300;
  localparam int unsigned WATCHDOG_NS =
    NR_INSNS * (ELEMS_PER_LANE + 10) * CLK_PERIOD + 60 * CLK_PERIOD;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              insn_valid_i;
  vec_op_e           op_i;
  logic [VREG_W-1:0] vd_i;
  logic [VREG_W-1:0] vs1_i;
  logic [VREG_W-1:0] vs2_i;
  logic [ELEM_W-1:0] scalar_i;
  logic              insn_ready_o;
  logic              resp_valid_o;
  logic [ELEM_W-1:0] resp_data_o;

  // Reference model state, indexed by global element
  logic [ELEM_W-1:0] ref_vrf [NR_VREGS][VLMAX];
  int                ref_vl = VLMAX;

  logic [31:0] lcg_state = 32'h963a99cb;
  int          n_checks  = 0;
  int          n_errors  = 0;
  int          stall_cnt = 0;
  int          assert_fails;

  vec_unit dut0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .insn_valid_i (insn_valid_i),
    .op_i         (op_i),
    .vd_i         (vd_i),
    .vs1_i        (vs1_i),
    .vs2_i        (vs2_i),
    .scalar_i     (scalar_i),
    .insn_ready_o (insn_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Cycles where a valid instruction waits on ready
  always @(negedge clk_i) begin
    if (!rst_i && insn_valid_i && !insn_ready_o) begin
      stall_cnt <= stall_cnt + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out at %0t, the DUT stopped answering", $time);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_val(input logic [ELEM_W-1:0] got, input logic [ELEM_W-1:0] exp,
                           input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // Caller is at a rising edge
  task automatic drive_insn(input vec_op_e op, input logic [VREG_W-1:0] vd,
                            input logic [VREG_W-1:0] vs1, input logic [VREG_W-1:0] vs2,
                            input logic [ELEM_W-1:0] s);
    insn_valid_i <= 1'b1;
    op_i         <= op;
    vd_i         <= vd;
    vs1_i        <= vs1;
    vs2_i        <= vs2;
    scalar_i     <= s;
  endtask

  // Returns at the accepting rising edge
  task automatic wait_accept();
    @(negedge clk_i);
    while (!insn_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic send_insn(input vec_op_e op, input logic [VREG_W-1:0] vd,
                           input logic [VREG_W-1:0] vs1, input logic [VREG_W-1:0] vs2,
                           input logic [ELEM_W-1:0] s);
    @(posedge clk_i);
    drive_insn(op, vd, vs1, vs2, s);
    wait_accept();
    insn_valid_i <= 1'b0;
  endtask

  // Response comes with the return of ready
  task automatic wait_done(output logic got_valid, output logic [ELEM_W-1:0] got);
    @(negedge clk_i);
    while (!insn_ready_o) begin
      check_val(32'(resp_valid_o), 0, "response while the unit is busy");
      @(negedge clk_i);
    end
    got_valid = resp_valid_o;
    got       = resp_data_o;
  endtask

  task automatic model_op(input vec_op_e op, input logic [VREG_W-1:0] vd,
                          input logic [VREG_W-1:0] vs1, input logic [VREG_W-1:0] vs2,
                          input logic [ELEM_W-1:0] s, output logic [ELEM_W-1:0] exp_scalar);
    logic [ELEM_W-1:0] a;
    logic [ELEM_W-1:0] b;
    exp_scalar = '0;
    // Elements at and above vl are never touched
    for (int e = 0; e < ref_vl; e++) begin
      a = ref_vrf[vs1][e];
      b = ref_vrf[vs2][e];
      case (op)
        OP_VADD_VV: ref_vrf[vd][e] = b + a;
        OP_VSUB_VV: ref_vrf[vd][e] = b - a;
        OP_VAND_VV: ref_vrf[vd][e] = b & a;
        OP_VOR_VV:  ref_vrf[vd][e] = b | a;
        OP_VXOR_VV: ref_vrf[vd][e] = b ^ a;
        OP_VADD_VX: ref_vrf[vd][e] = b + s;
        OP_VMV_V_X: ref_vrf[vd][e] = s;
        OP_VID:     ref_vrf[vd][e] = ELEM_W'(e);
        OP_VREDSUM: exp_scalar = exp_scalar + b;
        default: ;
      endcase
    end
    if (op == OP_VMV_X_S) begin
      exp_scalar = ref_vrf[vs2][int'(s)];
    end
  endtask

  task automatic run_op(input vec_op_e op, input logic [VREG_W-1:0] vd,
                        input logic [VREG_W-1:0] vs1, input logic [VREG_W-1:0] vs2,
                        input logic [ELEM_W-1:0] s);
    logic              got_valid;
    logic [ELEM_W-1:0] got;
    logic [ELEM_W-1:0] exp_scalar;
    send_insn(op, vd, vs1, vs2, s);
    wait_done(got_valid, got);
    model_op(op, vd, vs1, vs2, s, exp_scalar);
    if ((op == OP_VREDSUM) || (op == OP_VMV_X_S)) begin
      check_val(32'(got_valid), 1, $sformatf("%s response strobe", op.name()));
      check_val(got, exp_scalar, $sformatf("%s of v%0d, scalar %0d", op.name(), vs2, s));
    end else begin
      check_val(32'(got_valid), 0, $sformatf("%s gives no response", op.name()));
    end
  endtask

  task automatic set_vl(input logic [ELEM_W-1:0] req);
    logic [ELEM_W-1:0] exp_vl;
    exp_vl = (req > VLMAX) ? VLMAX : req;
    send_insn(OP_VSETVL, 0, 0, 0, req);
    @(negedge clk_i);
    check_val(32'(resp_valid_o), 1, "VSETVL response one cycle after accept");
    check_val(resp_data_o, exp_vl, $sformatf("VSETVL length for request %0d", req));
    check_val(32'(insn_ready_o), 1, "ready stays high on VSETVL");
    @(negedge clk_i);
    check_val(32'(resp_valid_o), 0, "VSETVL response lasts one cycle");
    ref_vl = int'(exp_vl);
  endtask

  task automatic check_reg(input logic [VREG_W-1:0] vreg);
    for (int e = 0; e < VLMAX; e++) begin
      run_op(OP_VMV_X_S, 0, 0, vreg, ELEM_W'(e));
    end
  endtask

  // Shrinking vl puts a separate random value in every element
  task automatic fill_random(input logic [VREG_W-1:0] vreg);
    for (int e = VLMAX - 1; e >= 0; e--) begin
      set_vl(ELEM_W'(e + 1));
      run_op(OP_VMV_V_X, vreg, 0, 0, lcg_next());
    end
    set_vl(VLMAX);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic after_reset();
    @(negedge clk_i);
    check_val(32'(insn_ready_o), 1, "insn_ready_o after reset");
    check_val(32'(resp_valid_o), 0, "resp_valid_o after reset");
  endtask

  task automatic vl_clamp();
    set_vl(0);
    set_vl(5);
    set_vl(VLMAX);
    set_vl(VLMAX + 1);
    set_vl(32'hffff_ffff);
    set_vl(VLMAX);
  endtask

  // Runs at the reset vl
  task automatic fill_and_read();
    run_op(OP_VID, 0, 0, 0, 0);
    run_op(OP_VMV_V_X, 1, 0, 0, lcg_next());
    check_reg(0);
    check_reg(1);
  endtask

  task automatic alu_ops();
    vec_op_e ops [6];
    ops = '{OP_VADD_VV, OP_VSUB_VV, OP_VAND_VV, OP_VOR_VV, OP_VXOR_VV, OP_VADD_VX};
    fill_random(2);
    fill_random(3);
    foreach (ops[i]) begin
      run_op(ops[i], 4, 2, 3, lcg_next());
      check_reg(4);
    end
  endtask

  task automatic tail_undisturbed();
    set_vl(5);
    run_op(OP_VSUB_VV, 4, 2, 3, 0);
    run_op(OP_VID, 1, 0, 0, 0);
    set_vl(VLMAX);
    check_reg(4);
    check_reg(1);
  endtask

  task automatic reduction_sums();
    run_op(OP_VREDSUM, 0, 0, 3, 0);
    set_vl(7);
    run_op(OP_VREDSUM, 0, 0, 2, 0);
    set_vl(0);
    run_op(OP_VREDSUM, 0, 0, 4, 0);
    set_vl(VLMAX);
  endtask

  // A second add of the scalar would show up in v4
  task automatic held_while_busy();
    logic              got_valid;
    logic [ELEM_W-1:0] got;
    logic [ELEM_W-1:0] s;
    logic [ELEM_W-1:0] unused;
    int                stalls_before;
    s = lcg_next();
    @(posedge clk_i);
    stalls_before = stall_cnt;
    drive_insn(OP_VOR_VV, 6, 2, 3, 0);
    wait_accept();
    drive_insn(OP_VADD_VX, 4, 0, 4, s);
    wait_accept();
    insn_valid_i <= 1'b0;
    wait_done(got_valid, got);
    check_val(32'(got_valid), 0, "VADD_VX after a held valid gives no response");
    check_val(32'(stall_cnt > stalls_before), 1, "second instruction held while busy");
    model_op(OP_VOR_VV, 6, 2, 3, 0, unused);
    model_op(OP_VADD_VX, 4, 0, 4, s, unused);
    check_reg(6);
    check_reg(4);
  endtask

  initial begin
    rst_i        = 1'b1;
    insn_valid_i = 1'b0;
    op_i         = OP_VSETVL;
    vd_i         = '0;
    vs1_i        = '0;
    vs2_i        = '0;
    scalar_i     = '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    after_reset();
    fill_and_read();
    vl_clamp();
    alu_ops();
    tail_undisturbed();
    reduction_sums();
    held_while_busy();
    assert_fails = dut0.assertions0.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, assert_fails);
    if ((n_errors == 0) && (assert_fails == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vec_unit.f */
rtl/vec_pkg.sv
rtl/vec_lane.sv
rtl/vec_sequencer.sv
rtl/vec_dispatcher.sv
rtl/vec_unit.sv
sim/vec_unit_assertions.sv
sim/vec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the vec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv \
  --top-module vec_unit_tb -Mdir "$BUILD_DIR" -o vec_unit_sim \
  -f vec_unit.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/vec_unit_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
exit 1
